// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
SIM_ARGS  ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
design/mips_mem_isa_pkg.sv
design/lsu_pkg.sv
design/mem_access_issue.sv
design/data_ram.sv
design/load_align.sv
design/lsu_top.sv
test/lsu_tb.sv

// File: design/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import mips_mem_isa_pkg::*, lsu_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset,

    input  wire logic                       issue_valid,
    input  wire mem_op_t                    issue_kind,
    input  wire logic [OFFSET_BITS-1:0]     issue_offset,
    input  wire logic [RAM_INDEX_BITS-1:0]  issue_index,
    input  wire logic [BYTES_PER_WORD-1:0]  byte_wen,
    input  wire logic [WORD_BITS-1:0]       wdata,
    input  wire logic [WORD_BITS-1:0]       issue_rt_old,
    input  wire logic                       issue_error,
    input  wire logic [EXC_CODE_BITS-1:0]   issue_error_code,

    output logic                            mem_valid,
    output mem_op_t                         mem_kind,
    output logic [OFFSET_BITS-1:0]          mem_offset,
    output logic [WORD_BITS-1:0]            mem_rt_old,
    output logic                            mem_error,
    output logic [EXC_CODE_BITS-1:0]        mem_error_code,
    output logic [WORD_BITS-1:0]            mem_rdata
);

    logic [WORD_BITS-1:0] ram [RAM_WORDS];

    // per-byte write lanes
    always_ff @(posedge clk) begin
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (byte_wen[b]) begin
                ram[issue_index][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    // read returns the word as it was before this edge's write
    always_ff @(posedge clk) begin
        mem_rdata <= ram[issue_index];
    end

    // EX/MEM boundary
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_kind       <= issue_kind;
        mem_offset     <= issue_offset;
        mem_rt_old     <= issue_rt_old;
        mem_error      <= issue_error;
        mem_error_code <= issue_error_code;
    end

endmodule

`default_nettype wire

// File: design/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align
    import mips_mem_isa_pkg::*, lsu_pkg::*;
(
    input  wire logic                       mem_valid,
    input  wire mem_op_t                    mem_kind,
    input  wire logic [OFFSET_BITS-1:0]     mem_offset,
    input  wire logic [WORD_BITS-1:0]       mem_rt_old,
    input  wire logic                       mem_error,
    input  wire logic [EXC_CODE_BITS-1:0]   mem_error_code,
    input  wire logic [WORD_BITS-1:0]       mem_rdata,

    output logic                            rsp_valid,
    output logic [WORD_BITS-1:0]            load_data,
    output logic                            addr_error,
    output logic [EXC_CODE_BITS-1:0]        error_code
);

    mem_word_t            word;
    logic [7:0]           sel_byte;
    logic [15:0]          sel_half;
    logic [4:0]           shl_amt;
    logic [4:0]           shr_amt;
    logic [WORD_BITS-1:0] lwl_merged;
    logic [WORD_BITS-1:0] lwr_merged;
    logic [WORD_BITS-1:0] extracted;

    assign word = mem_rdata;

    // byte lane k, halfword lane k/2
    assign sel_byte = word.bytes[mem_offset];
    assign sel_half = word.halves[mem_offset[1]];

    assign shl_amt = {~mem_offset, 3'b000};
    assign shr_amt = {mem_offset, 3'b000};

    // lwl keeps the low 3-k bytes of rt
    assign lwl_merged = (mem_rdata << shl_amt)
                      | (mem_rt_old & (32'h00ff_ffff >> shr_amt));

    // lwr keeps the high k bytes of rt
    assign lwr_merged = (mem_rdata >> shr_amt)
                      | (mem_rt_old & ~(32'hffff_ffff >> shr_amt));

    always_comb begin
        case (mem_kind)
            op_lb: begin
                extracted = {{24{sel_byte[7]}}, sel_byte};
            end
            op_lbu: begin
                extracted = {24'h0, sel_byte};
            end
            op_lh: begin
                extracted = {{16{sel_half[15]}}, sel_half};
            end
            op_lhu: begin
                extracted = {16'h0, sel_half};
            end
            op_lw: begin
                extracted = mem_rdata;
            end
            op_lwl: begin
                extracted = lwl_merged;
            end
            op_lwr: begin
                extracted = lwr_merged;
            end
            default: begin
                // stores return nothing useful
                extracted = '0;
            end
        endcase
    end

    assign rsp_valid  = mem_valid;
    assign addr_error = mem_valid & mem_error;

    // faulting loads return zero
    assign load_data  = mem_error ? '0 : extracted;
    assign error_code = addr_error ? mem_error_code : EXC_NONE;

endmodule

`default_nettype wire

// File: design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int BYTES_PER_WORD = 4;

    // byte offset inside a word
    localparam int OFFSET_BITS = 2;

    // data memory depth in words
    localparam int RAM_WORDS = 256;
    localparam int RAM_INDEX_BITS = 8;

    // one memory word, two ways to look at it
    // lane 0 is the least significant, little endian
    typedef union packed {
        logic [BYTES_PER_WORD-1:0][7:0] bytes;
        logic [1:0][15:0]               halves;
    } mem_word_t;

endpackage

`default_nettype wire

// File: design/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import mips_mem_isa_pkg::*, lsu_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset,

    input  wire logic                       op_valid,
    input  wire mem_op_t                    op_kind,
    input  wire logic [WORD_BITS-1:0]       addr,
    input  wire logic [WORD_BITS-1:0]       store_data,
    input  wire logic [WORD_BITS-1:0]       rt_old,

    output logic                            rsp_valid,
    output logic [WORD_BITS-1:0]            load_data,
    output logic                            addr_error,
    output logic [EXC_CODE_BITS-1:0]        error_code
);

    // EX side
    logic                      issue_valid;
    mem_op_t                   issue_kind;
    logic [OFFSET_BITS-1:0]    issue_offset;
    logic [RAM_INDEX_BITS-1:0] issue_index;
    logic [BYTES_PER_WORD-1:0] byte_wen;
    logic [WORD_BITS-1:0]      wdata;
    logic [WORD_BITS-1:0]      issue_rt_old;
    logic                      issue_error;
    logic [EXC_CODE_BITS-1:0]  issue_error_code;

    // MEM side
    logic                      mem_valid;
    mem_op_t                   mem_kind;
    logic [OFFSET_BITS-1:0]    mem_offset;
    logic [WORD_BITS-1:0]      mem_rt_old;
    logic                      mem_error;
    logic [EXC_CODE_BITS-1:0]  mem_error_code;
    logic [WORD_BITS-1:0]      mem_rdata;

    mem_access_issue mem_access_issue_inst (
        .op_valid         (op_valid),
        .op_kind          (op_kind),
        .addr             (addr),
        .store_data       (store_data),
        .rt_old           (rt_old),
        .issue_valid      (issue_valid),
        .issue_kind       (issue_kind),
        .issue_offset     (issue_offset),
        .issue_index      (issue_index),
        .byte_wen         (byte_wen),
        .wdata            (wdata),
        .issue_rt_old     (issue_rt_old),
        .issue_error      (issue_error),
        .issue_error_code (issue_error_code)
    );

    data_ram data_ram_inst (
        .clk              (clk),
        .reset            (reset),
        .issue_valid      (issue_valid),
        .issue_kind       (issue_kind),
        .issue_offset     (issue_offset),
        .issue_index      (issue_index),
        .byte_wen         (byte_wen),
        .wdata            (wdata),
        .issue_rt_old     (issue_rt_old),
        .issue_error      (issue_error),
        .issue_error_code (issue_error_code),
        .mem_valid        (mem_valid),
        .mem_kind         (mem_kind),
        .mem_offset       (mem_offset),
        .mem_rt_old       (mem_rt_old),
        .mem_error        (mem_error),
        .mem_error_code   (mem_error_code),
        .mem_rdata        (mem_rdata)
    );

    load_align load_align_inst (
        .mem_valid        (mem_valid),
        .mem_kind         (mem_kind),
        .mem_offset       (mem_offset),
        .mem_rt_old       (mem_rt_old),
        .mem_error        (mem_error),
        .mem_error_code   (mem_error_code),
        .mem_rdata        (mem_rdata),
        .rsp_valid        (rsp_valid),
        .load_data        (load_data),
        .addr_error       (addr_error),
        .error_code       (error_code)
    );

endmodule

`default_nettype wire

// File: design/mem_access_issue.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_issue
    import mips_mem_isa_pkg::*, lsu_pkg::*;
(
    input  wire logic                       op_valid,
    input  wire mem_op_t                    op_kind,
    input  wire logic [WORD_BITS-1:0]       addr,
    input  wire logic [WORD_BITS-1:0]       store_data,
    input  wire logic [WORD_BITS-1:0]       rt_old,

    output logic                            issue_valid,
    output mem_op_t                         issue_kind,
    output logic [OFFSET_BITS-1:0]          issue_offset,
    output logic [RAM_INDEX_BITS-1:0]       issue_index,
    output logic [BYTES_PER_WORD-1:0]       byte_wen,
    output logic [WORD_BITS-1:0]            wdata,
    output logic [WORD_BITS-1:0]            issue_rt_old,
    output logic                            issue_error,
    output logic [EXC_CODE_BITS-1:0]        issue_error_code
);

    logic                      is_store;
    logic                      misaligned;
    logic [BYTES_PER_WORD-1:0] wen_raw;
    logic [4:0]                shl_amt;
    logic [4:0]                shr_amt;

    assign issue_valid  = op_valid;
    assign issue_kind   = op_kind;
    assign issue_rt_old = rt_old;

    // upper address bits fall outside the memory
    assign issue_offset = addr[OFFSET_BITS-1:0];
    assign issue_index  = addr[OFFSET_BITS +: RAM_INDEX_BITS];

    // 8*k and 8*(3-k)
    assign shl_amt = {issue_offset, 3'b000};
    assign shr_amt = {~issue_offset, 3'b000};

    always_comb begin
        is_store   = 1'b0;
        misaligned = 1'b0;
        wen_raw    = '0;
        wdata      = store_data;
        case (op_kind)
            op_lw: begin
                misaligned = (issue_offset != '0);
            end
            op_lh, op_lhu: begin
                misaligned = issue_offset[0];
            end
            op_sb: begin
                is_store = 1'b1;
                wen_raw  = 4'b0001 << issue_offset;
                wdata    = {4{store_data[7:0]}};
            end
            op_sh: begin
                is_store   = 1'b1;
                misaligned = issue_offset[0];
                wen_raw    = 4'b0011 << issue_offset;
                wdata      = {2{store_data[15:0]}};
            end
            op_sw: begin
                is_store   = 1'b1;
                misaligned = (issue_offset != '0);
                wen_raw    = 4'b1111;
            end
            op_swl: begin
                // high bytes of rt land in bytes 0..k
                is_store = 1'b1;
                wen_raw  = 4'b1111 >> (2'd3 - issue_offset);
                wdata    = store_data >> shr_amt;
            end
            op_swr: begin
                // low bytes of rt land in bytes k..3
                is_store = 1'b1;
                wen_raw  = 4'b1111 << issue_offset;
                wdata    = store_data << shl_amt;
            end
            default: begin
                // byte loads and lwl/lwr never fault
                misaligned = 1'b0;
            end
        endcase
    end

    assign issue_error = op_valid & misaligned;

    // a faulting store must not touch memory
    assign byte_wen = (op_valid && !misaligned) ? wen_raw : '0;

    always_comb begin
        if (!misaligned) begin
            issue_error_code = EXC_NONE;
        end else if (is_store) begin
            issue_error_code = EXC_ADES;
        end else begin
            issue_error_code = EXC_ADEL;
        end
    end

endmodule

`default_nettype wire

// File: design/mips_mem_isa_pkg.sv
`default_nettype none

package mips_mem_isa_pkg;

    // data path and address width
    localparam int WORD_BITS = 32;

    // cause register exccode field
    localparam int EXC_CODE_BITS = 5;

    localparam logic [EXC_CODE_BITS-1:0] EXC_NONE = 5'd0;
    // misaligned load
    localparam logic [EXC_CODE_BITS-1:0] EXC_ADEL = 5'd4;
    // misaligned store
    localparam logic [EXC_CODE_BITS-1:0] EXC_ADES = 5'd5;

    // memory access kinds
    typedef enum logic [3:0] {
        op_lb  = 4'd0,
        op_lbu = 4'd1,
        op_lh  = 4'd2,
        op_lhu = 4'd3,
        op_lw  = 4'd4,
        // unaligned word loads, merged with old rt
        op_lwl = 4'd5,
        op_lwr = 4'd6,
        op_sb  = 4'd7,
        op_sh  = 4'd8,
        op_sw  = 4'd9,
        // unaligned word stores, partial strobes
        op_swl = 4'd10,
        op_swr = 4'd11
    } mem_op_t;

endpackage

`default_nettype wire

// File: test/lsu_stimulus.txt
# kind addr store_data rt_old exp_data exp_code, all hex, one operation per line
# kind: 0 lb 1 lbu 2 lh 3 lhu 4 lw 5 lwl 6 lwr 7 sb 8 sh 9 sw a swl b swr
# kind plus 10 issues on the cycle right after the previous operation
9 00000100 8badf00d 00000000 00000000 00
4 00000100 00000000 00000000 8badf00d 00
7 00000104 000000a1 00000000 00000000 00
7 00000105 123456b2 00000000 00000000 00
8 00000106 9999c3d4 00000000 00000000 00
4 00000104 00000000 00000000 c3d4b2a1 00
0 00000104 00000000 00000000 ffffffa1 00
10 00000105 00000000 00000000 ffffffb2 00
10 00000106 00000000 00000000 ffffffd4 00
10 00000107 00000000 00000000 ffffffc3 00
1 00000100 00000000 00000000 0000000d 00
1 00000101 00000000 00000000 000000f0 00
1 00000102 00000000 00000000 000000ad 00
1 00000103 00000000 00000000 0000008b 00
2 00000104 00000000 00000000 ffffb2a1 00
2 00000106 00000000 00000000 ffffc3d4 00
3 00000100 00000000 00000000 0000f00d 00
3 00000102 00000000 00000000 00008bad 00
5 00000100 00000000 11223344 0d223344 00
5 00000101 00000000 11223344 f00d3344 00
5 00000102 00000000 11223344 adf00d44 00
5 00000103 00000000 11223344 8badf00d 00
6 00000100 00000000 11223344 8badf00d 00
6 00000101 00000000 11223344 118badf0 00
6 00000102 00000000 11223344 11228bad 00
6 00000103 00000000 11223344 1122338b 00
a 00000203 a1b2c3d4 00000000 00000000 00
4 00000200 00000000 00000000 a1b2c3d4 00
a 00000200 11223344 00000000 00000000 00
14 00000200 00000000 00000000 a1b2c311 00
a 00000201 55667788 00000000 00000000 00
4 00000200 00000000 00000000 a1b25566 00
a 00000202 99aabbcc 00000000 00000000 00
4 00000200 00000000 00000000 a199aabb 00
b 00000204 a1b2c3d4 00000000 00000000 00
4 00000204 00000000 00000000 a1b2c3d4 00
b 00000205 11223344 00000000 00000000 00
4 00000204 00000000 00000000 223344d4 00
b 00000206 55667788 00000000 00000000 00
4 00000204 00000000 00000000 778844d4 00
b 00000207 99aabbcc 00000000 00000000 00
4 00000204 00000000 00000000 cc8844d4 00
4 00000101 00000000 00000000 00000000 04
2 00000103 00000000 00000000 00000000 04
3 00000101 00000000 00000000 00000000 04
9 00000102 deadbeef 00000000 00000000 05
8 00000101 deadbeef 00000000 00000000 05
4 00000100 00000000 00000000 8badf00d 00
9 00000300 0badcafe 00000000 00000000 00
14 00000300 00000000 00000000 0badcafe 00
17 00000302 0000005a 00000000 00000000 00
10 00000302 00000000 00000000 0000005a 00
14 00000300 00000000 00000000 0b5acafe 00

// File: test/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import mips_mem_isa_pkg::*;
();

    localparam int    RESET_CYCLES = 16;
    localparam string STIM_FILE    = "test/lsu_stimulus.txt";

    logic                     clk;
    logic                     reset;
    logic                     op_valid;
    mem_op_t                  op_kind;
    logic [WORD_BITS-1:0]     addr;
    logic [WORD_BITS-1:0]     store_data;
    logic [WORD_BITS-1:0]     rt_old;
    logic                     rsp_valid;
    logic [WORD_BITS-1:0]     load_data;
    logic                     addr_error;
    logic [EXC_CODE_BITS-1:0] error_code;

    // one entry per stimulus line
    logic [7:0]  stim_kind [$];
    logic [31:0] stim_addr [$];
    logic [31:0] stim_wdata [$];
    logic [31:0] stim_rt [$];
    logic [31:0] stim_data [$];
    logic [7:0]  stim_code [$];

    // expectations for operations in flight
    logic [7:0]  exp_kind_q [$];
    logic [31:0] exp_data_q [$];
    logic [7:0]  exp_code_q [$];
    logic        rsp_due;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    lsu_top lsu_top_inst (
        .clk        (clk),
        .reset      (reset),
        .op_valid   (op_valid),
        .op_kind    (op_kind),
        .addr       (addr),
        .store_data (store_data),
        .rt_old     (rt_old),
        .rsp_valid  (rsp_valid),
        .load_data  (load_data),
        .addr_error (addr_error),
        .error_code (error_code)
    );

    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // load_data carries nothing for stores
    function automatic logic is_store(input logic [3:0] kind);
        case (mem_op_t'(kind))
            op_sb, op_sh, op_sw, op_swl, op_swr: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  k;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] r;
        logic [31:0] d;
        logic [7:0]  c;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                // skip comments and blank lines
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h", k, a, w, r, d, c);
                    if (n != 6) begin
                        abort_run({"malformed stimulus line: ", line});
                    end else begin
                        stim_kind.push_back(k);
                        stim_addr.push_back(a);
                        stim_wdata.push_back(w);
                        stim_rt.push_back(r);
                        stim_data.push_back(d);
                        stim_code.push_back(c);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_response();
        logic [7:0]  kind;
        logic [31:0] data;
        logic [7:0]  code;
        kind = exp_kind_q.pop_front();
        data = exp_data_q.pop_front();
        code = exp_code_q.pop_front();
        if (!is_store(kind[3:0])) begin
            check_value("load_data", load_data, data);
        end
        check_value("error_code", 32'(error_code), 32'(code[4:0]));
        check_value("addr_error", 32'(addr_error), 32'(code != 8'h00));
    endtask

    // response must show up exactly one cycle after issue
    always @(negedge clk) begin
        if (!reset) begin
            rsp_due <= op_valid;
            if (rsp_due && rsp_valid !== 1'b1) begin
                abort_run("an operation got no response one cycle after issue");
            end else if (!rsp_due && rsp_valid !== 1'b0) begin
                abort_run("rsp_valid rose with no operation outstanding");
            end else if (rsp_due) begin
                check_response();
            end
        end
    end

    initial begin
        int n_ops;
        int idle;
        void'($urandom(32'hd5e5_cc8c));
        reset      = 1'b1;
        op_valid   = 1'b0;
        op_kind    = op_lb;
        addr       = '0;
        store_data = '0;
        rt_old     = '0;
        rsp_due    = 1'b0;
        load_stimulus();
        n_ops = stim_kind.size();
        fork
            begin
                #((RESET_CYCLES + 4 * n_ops) * 100);
                abort_run("timeout, the run did not finish in time");
            end
        join_none
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < n_ops; i++) begin
            // bit 4 of the kind column asks for back-to-back issue
            if (!stim_kind[i][4]) begin
                idle = $urandom % 3;
                repeat (idle) begin
                    @(posedge clk);
                    op_valid <= 1'b0;
                end
            end
            @(posedge clk);
            op_valid   <= 1'b1;
            op_kind    <= mem_op_t'(stim_kind[i][3:0]);
            addr       <= stim_addr[i];
            store_data <= stim_wdata[i];
            rt_old     <= stim_rt[i];
            exp_kind_q.push_back(stim_kind[i]);
            exp_data_q.push_back(stim_data[i]);
            exp_code_q.push_back(stim_code[i]);
        end
        @(posedge clk);
        op_valid <= 1'b0;
        while (exp_kind_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        if (n_ops == 0) begin
            abort_run("the stimulus file holds no operations");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
